//--- filelist.f
hw/seqRegPkg.sv
hw/intrPkg.sv
hw/irqInputSync.sv
hw/irqFlags.sv
hw/maskStack.sv
hw/intrArbiter.sv
hw/intrCtrlRegs.sv
hw/intrCtrl.sv
testbench/tbIntrCtrl.sv

//--- hw/intrArbiter.sv
`timescale 1ns/1ps

module intrArbiter (
  input  logic                      DSPCLK,
  input  logic                      SRST,
  input  intrPkg::intrVec_t         flags_i,
  input  seqRegPkg::icntl_t         icntl_i,
  input  logic                      takeInt_i,
  input  logic                      rti_i,
  input  logic                      maskWe_i,
  input  intrPkg::intrVec_t         maskData_i,
  output logic                      trapReq_o,
  output intrPkg::intrVec_t         accepted_o,
  output intrPkg::intrVec_t         mask_o,
  output logic [intrPkg::ADDR_W-1:0] vector_o,
  output logic                      stackEmpty_o,
  output logic                      stackOverflow_o
);

  intrPkg::intrVec_t             pending;
  intrPkg::intrVec_t             winner;
  intrPkg::intrVec_t             keepAbove;
  intrPkg::intrVec_t             newMask;
  intrPkg::intrVec_t             topMask;
  logic [intrPkg::ADDR_W-1:0]    winVector;
  logic                          acceptTake;
  logic                          doPop;

  ////////////////////////////////
  // priority pick
  ////////////////////////////////
  assign pending = flags_i & mask_o;

  // ascending scan, last hit is the highest index
  always_comb begin
    winner    = '0;
    winVector = '0;
    keepAbove = '0;
    for (int i = 0; i < intrPkg::NUM_SRC; i++) begin
      if (pending[i]) begin
        winner    = '0;
        winner[i] = 1'b1;
        winVector = intrPkg::VECTOR_TABLE[i];
        keepAbove = {intrPkg::NUM_SRC{1'b1}} << (i + 1);
      end
    end
  end

  assign trapReq_o  = (|pending) && icntl_i.globalEn;
  assign acceptTake = takeInt_i && trapReq_o;
  assign accepted_o = acceptTake ? winner : '0;

  // nesting lets only higher sources through
  assign newMask = icntl_i.nest ? (mask_o & keepAbove) : '0;

  assign doPop = rti_i && !acceptTake;

  ////////////////////////////////
  // mask and vector
  ////////////////////////////////
  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      mask_o <= '0;
    end else if (acceptTake) begin
      mask_o <= newMask;
    end else if (doPop && !stackEmpty_o) begin
      mask_o <= topMask;
    end else if (maskWe_i) begin
      mask_o <= maskData_i;
    end
  end

  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      vector_o <= '0;
    end else if (acceptTake) begin
      vector_o <= winVector;
    end
  end

  // old mask saved on every accepted take
  maskStack uMaskStack (
    .DSPCLK     (DSPCLK),
    .SRST       (SRST),
    .push_i     (acceptTake),
    .pop_i      (doPop),
    .pushMask_i (mask_o),
    .topMask_o  (topMask),
    .empty_o    (stackEmpty_o),
    .overflow_o (stackOverflow_o)
  );

endmodule

//--- hw/intrCtrl.sv
`timescale 1ns/1ps

module intrCtrl (
  input  logic                         DSPCLK,
  input  logic                         SRST,
  input  intrPkg::irqPins_t            irqPins_i,
  input  intrPkg::periphReq_t          periphReq_i,
  input  seqRegPkg::regWrite_t         regWr_i,
  input  seqRegPkg::regAddr_e          regRdAddr_i,
  input  logic                         takeInt_i,
  input  logic                         rti_i,
  output logic                         trapReq_o,
  output logic [intrPkg::ADDR_W-1:0]   vector_o,
  output logic [seqRegPkg::DATA_W-1:0] regRdData_o
);

  intrPkg::intrVec_t pinLevel;
  intrPkg::intrVec_t pinEdge;
  intrPkg::intrVec_t flags;
  intrPkg::intrVec_t accepted;
  intrPkg::intrVec_t mask;
  intrPkg::intrVec_t maskData;
  intrPkg::intrVec_t forcePulse;
  intrPkg::intrVec_t clearPulse;
  seqRegPkg::icntl_t icntl;
  logic              maskWe;
  logic              stackEmpty;
  logic              stackOverflow;

  irqInputSync uInputSync (
    .DSPCLK     (DSPCLK),
    .SRST       (SRST),
    .irqPins_i  (irqPins_i),
    .pinLevel_o (pinLevel),
    .pinEdge_o  (pinEdge)
  );

  irqFlags uFlags (
    .DSPCLK       (DSPCLK),
    .SRST         (SRST),
    .pinLevel_i   (pinLevel),
    .pinEdge_i    (pinEdge),
    .periphReq_i  (periphReq_i),
    .icntl_i      (icntl),
    .forcePulse_i (forcePulse),
    .clearPulse_i (clearPulse),
    .accepted_i   (accepted),
    .flags_o      (flags)
  );

  intrArbiter uArbiter (
    .DSPCLK          (DSPCLK),
    .SRST            (SRST),
    .flags_i         (flags),
    .icntl_i         (icntl),
    .takeInt_i       (takeInt_i),
    .rti_i           (rti_i),
    .maskWe_i        (maskWe),
    .maskData_i      (maskData),
    .trapReq_o       (trapReq_o),
    .accepted_o      (accepted),
    .mask_o          (mask),
    .vector_o        (vector_o),
    .stackEmpty_o    (stackEmpty),
    .stackOverflow_o (stackOverflow)
  );

  intrCtrlRegs uRegs (
    .DSPCLK          (DSPCLK),
    .SRST            (SRST),
    .regWr_i         (regWr_i),
    .regRdAddr_i     (regRdAddr_i),
    .flags_i         (flags),
    .mask_i          (mask),
    .stackEmpty_i    (stackEmpty),
    .stackOverflow_i (stackOverflow),
    .icntl_o         (icntl),
    .maskWe_o        (maskWe),
    .maskData_o      (maskData),
    .forcePulse_o    (forcePulse),
    .clearPulse_o    (clearPulse),
    .regRdData_o     (regRdData_o)
  );

endmodule

//--- hw/intrCtrlRegs.sv
`timescale 1ns/1ps

module intrCtrlRegs (
  input  logic                         DSPCLK,
  input  logic                         SRST,
  input  seqRegPkg::regWrite_t         regWr_i,
  input  seqRegPkg::regAddr_e          regRdAddr_i,
  input  intrPkg::intrVec_t            flags_i,
  input  intrPkg::intrVec_t            mask_i,
  input  logic                         stackEmpty_i,
  input  logic                         stackOverflow_i,
  output seqRegPkg::icntl_t            icntl_o,
  output logic                         maskWe_o,
  output intrPkg::intrVec_t            maskData_o,
  output intrPkg::intrVec_t            forcePulse_o,
  output intrPkg::intrVec_t            clearPulse_o,
  output logic [seqRegPkg::DATA_W-1:0] regRdData_o
);

  logic ifcWe;
  logic icntlWe;

  assign ifcWe    = regWr_i.we && (regWr_i.addr == seqRegPkg::REG_IFC);
  assign icntlWe  = regWr_i.we && (regWr_i.addr == seqRegPkg::REG_ICNTL);
  assign maskWe_o = regWr_i.we && (regWr_i.addr == seqRegPkg::REG_IMASK);

  assign maskData_o = regWr_i.data[intrPkg::NUM_SRC-1:0];

  // IFC is write-only, pulses last the write cycle
  assign clearPulse_o = ifcWe ?
    regWr_i.data[seqRegPkg::IFC_CLR_LSB +: intrPkg::NUM_SRC] : '0;
  assign forcePulse_o = ifcWe ?
    regWr_i.data[seqRegPkg::IFC_FORCE_LSB +: intrPkg::NUM_SRC] : '0;

  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      icntl_o <= '0;
    end else if (icntlWe) begin
      icntl_o <= seqRegPkg::icntl_t'(regWr_i.data[$bits(seqRegPkg::icntl_t)-1:0]);
    end
  end

  ////////////////////////////////
  // read-back
  ////////////////////////////////
  always_comb begin
    regRdData_o = '0;
    case (regRdAddr_i)
      seqRegPkg::REG_IMASK: regRdData_o[intrPkg::NUM_SRC-1:0] = mask_i;
      seqRegPkg::REG_ICNTL: regRdData_o[$bits(seqRegPkg::icntl_t)-1:0] = icntl_o;
      seqRegPkg::REG_IFLAG: regRdData_o[intrPkg::NUM_SRC-1:0] = flags_i;
      seqRegPkg::REG_SSTAT: regRdData_o[1:0] = {stackOverflow_i, stackEmpty_i};
      default: regRdData_o = '0;
    endcase
  end

endmodule

//--- hw/intrPkg.sv
package intrPkg;

  localparam int NUM_SRC = 6;

  // bit index of each source, higher index wins
  typedef enum logic [2:0] {
    TIMER = 3'd0,
    SPORT = 3'd1,
    IRQ0  = 3'd2,
    IRQ1  = 3'd3,
    IRQE  = 3'd4,
    IRQ2  = 3'd5
  } intrSrc_e;

  typedef logic [NUM_SRC-1:0] intrVec_t;

  ////////////////////////////////
  // vectors
  ////////////////////////////////
  localparam int ADDR_W = 14;

  // indexed by source, IRQ2 entry first in the concatenation
  localparam logic [NUM_SRC-1:0][ADDR_W-1:0] VECTOR_TABLE = {
    14'h0004,
    14'h0008,
    14'h000C,
    14'h0010,
    14'h0014,
    14'h0018
  };

  ////////////////////////////////
  // mask stack
  ////////////////////////////////
  localparam int MASK_STACK_DEPTH = 4;
  localparam int STACK_IDX_W      = $clog2(MASK_STACK_DEPTH);
  localparam int STACK_PTR_W      = STACK_IDX_W + 1;

  // pins are active low
  typedef struct packed {
    logic irq2n;
    logic irqen;
    logic irq1n;
    logic irq0n;
  } irqPins_t;

  typedef struct packed {
    logic timer;
    logic sport;
  } periphReq_t;

endpackage

//--- hw/irqFlags.sv
`timescale 1ns/1ps

module irqFlags (
  input  logic                 DSPCLK,
  input  logic                 SRST,
  input  intrPkg::intrVec_t    pinLevel_i,
  input  intrPkg::intrVec_t    pinEdge_i,
  input  intrPkg::periphReq_t  periphReq_i,
  input  seqRegPkg::icntl_t    icntl_i,
  input  intrPkg::intrVec_t    forcePulse_i,
  input  intrPkg::intrVec_t    clearPulse_i,
  input  intrPkg::intrVec_t    accepted_i,
  output intrPkg::intrVec_t    flags_o
);

  intrPkg::intrVec_t setVec;
  intrPkg::intrVec_t clrVec;
  intrPkg::intrVec_t levelMode;
  intrPkg::intrVec_t latchNext;
  intrPkg::intrVec_t flagsNext;

  ////////////////////////////////
  // set and clear sources
  ////////////////////////////////
  always_comb begin
    setVec = pinEdge_i | forcePulse_i;
    setVec[intrPkg::TIMER] = setVec[intrPkg::TIMER] | periphReq_i.timer;
    setVec[intrPkg::SPORT] = setVec[intrPkg::SPORT] | periphReq_i.sport;
  end

  assign clrVec = clearPulse_i | accepted_i;

  // only the three general pins can run in level mode
  always_comb begin
    levelMode = '0;
    levelMode[intrPkg::IRQ0] = ~icntl_i.irq0Edge;
    levelMode[intrPkg::IRQ1] = ~icntl_i.irq1Edge;
    levelMode[intrPkg::IRQ2] = ~icntl_i.irq2Edge;
  end

  ////////////////////////////////
  // flag update
  ////////////////////////////////

  // clear beats set
  assign latchNext = (flags_o | setVec) & ~clrVec;

  // level sources follow the pin and ignore force, clear and acceptance
  assign flagsNext = (latchNext & ~levelMode) | (pinLevel_i & levelMode);

  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      flags_o <= '0;
    end else begin
      flags_o <= flagsNext;
    end
  end

endmodule

//--- hw/irqInputSync.sv
`timescale 1ns/1ps

module irqInputSync (
  input  logic              DSPCLK,
  input  logic              SRST,
  input  intrPkg::irqPins_t irqPins_i,
  output intrPkg::intrVec_t pinLevel_o,
  output intrPkg::intrVec_t pinEdge_o
);

  intrPkg::intrVec_t pinRaw;
  intrPkg::intrVec_t syncS1;
  intrPkg::intrVec_t syncS2;
  intrPkg::intrVec_t syncS3;

  // active-high copy in source bit order
  always_comb begin
    pinRaw = '0;
    pinRaw[intrPkg::IRQ2] = ~irqPins_i.irq2n;
    pinRaw[intrPkg::IRQE] = ~irqPins_i.irqen;
    pinRaw[intrPkg::IRQ1] = ~irqPins_i.irq1n;
    pinRaw[intrPkg::IRQ0] = ~irqPins_i.irq0n;
  end

  ////////////////////////////////
  // synchronizer
  ////////////////////////////////
  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      syncS1 <= '0;
      syncS2 <= '0;
    end else begin
      syncS1 <= pinRaw;
      syncS2 <= syncS1;
    end
  end

  // third stage only feeds the edge detect
  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      syncS3 <= '0;
    end else begin
      syncS3 <= syncS2;
    end
  end

  assign pinLevel_o = syncS2;

  // high for one cycle after the pin goes low
  assign pinEdge_o = syncS2 & ~syncS3;

endmodule

//--- hw/maskStack.sv
`timescale 1ns/1ps

module maskStack (
  input  logic              DSPCLK,
  input  logic              SRST,
  input  logic              push_i,
  input  logic              pop_i,
  input  intrPkg::intrVec_t pushMask_i,
  output intrPkg::intrVec_t topMask_o,
  output logic              empty_o,
  output logic              overflow_o
);

  intrPkg::intrVec_t stackMem [intrPkg::MASK_STACK_DEPTH];

  // number of entries held
  logic [intrPkg::STACK_PTR_W-1:0] depth;
  logic [intrPkg::STACK_PTR_W-1:0] topIdx;
  logic                            full;

  assign full    = depth == intrPkg::STACK_PTR_W'(intrPkg::MASK_STACK_DEPTH);
  assign empty_o = depth == '0;
  assign topIdx  = depth - 1'b1;

  assign topMask_o = empty_o ? '0 : stackMem[topIdx[intrPkg::STACK_IDX_W-1:0]];

  always_ff @(posedge DSPCLK) begin
    if (push_i && !full) begin
      stackMem[depth[intrPkg::STACK_IDX_W-1:0]] <= pushMask_i;
    end
  end

  // push on full loses the entry, overflow stays until reset
  always_ff @(posedge DSPCLK or posedge SRST) begin
    if (SRST) begin
      depth      <= '0;
      overflow_o <= 1'b0;
    end else if (push_i) begin
      if (full) begin
        overflow_o <= 1'b1;
      end else begin
        depth <= depth + 1'b1;
      end
    end else if (pop_i && !empty_o) begin
      depth <= depth - 1'b1;
    end
  end

endmodule

//--- hw/seqRegPkg.sv
package seqRegPkg;

  // register data bus
  localparam int DATA_W = 16;

  // IFC write layout, clear bits low and force bits high
  localparam int IFC_CLR_LSB   = 0;
  localparam int IFC_FORCE_LSB = 8;

  typedef enum logic [2:0] {
    REG_IMASK = 3'd0,
    REG_ICNTL = 3'd1,
    REG_IFC   = 3'd2,
    REG_IFLAG = 3'd3,
    REG_SSTAT = 3'd4
  } regAddr_e;

  typedef struct packed {
    logic              we;
    regAddr_e          addr;
    logic [DATA_W-1:0] data;
  } regWrite_t;

  // edge bits: 1 selects edge mode, 0 level mode
  typedef struct packed {
    logic nest;
    logic globalEn;
    logic irq2Edge;
    logic irq1Edge;
    logic irq0Edge;
  } icntl_t;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbIntrCtrl \
  -f filelist.f --Mdir obj_dir -o simIntrCtrl

./obj_dir/simIntrCtrl > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

//--- testbench/tbIntrCtrl.sv
`timescale 1ns/1ps

module tbIntrCtrl;

  // all tests together run about 900 cycles
  localparam int TEST_CYCLES    = 900;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
  localparam int TRAP_WAIT      = 8;
  localparam int FLAG_WAIT      = 8;
  localparam int RAND_ITERS     = 24;

  typedef struct packed {
    logic              hit;
    logic [2:0]        winner;
    logic [13:0]       vector;
    intrPkg::intrVec_t newMask;
  } refResult_t;

  logic                 DSPCLK;
  logic                 SRST;
  intrPkg::irqPins_t    irqPins;
  intrPkg::periphReq_t  periphReq;
  seqRegPkg::regWrite_t regWr;
  seqRegPkg::regAddr_e  regRdAddr;
  logic                 takeInt;
  logic                 rti;
  logic                 trapReq;
  logic [13:0]          vector;
  logic [15:0]          regRdData;

  int                   errCount = 0;
  int                   checkCount = 0;
  int                   cycleCount = 0;
  intrPkg::intrVec_t    expMask;
  logic                 expOvf;
  intrPkg::intrVec_t    stackModel[$];
  seqRegPkg::icntl_t    curIcntl;

  intrCtrl DUT (
    .DSPCLK      (DSPCLK),
    .SRST        (SRST),
    .irqPins_i   (irqPins),
    .periphReq_i (periphReq),
    .regWr_i     (regWr),
    .regRdAddr_i (regRdAddr),
    .takeInt_i   (takeInt),
    .rti_i       (rti),
    .trapReq_o   (trapReq),
    .vector_o    (vector),
    .regRdData_o (regRdData)
  );

  initial begin
    DSPCLK = 1'b0;
    forever #2 DSPCLK = ~DSPCLK;
  end

  always @(posedge DSPCLK) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("timeout, the run went past %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic logic [13:0] expVector(input int src);
    case (src)
      5: return 14'h0004;
      4: return 14'h0008;
      3: return 14'h000C;
      2: return 14'h0010;
      1: return 14'h0014;
      0: return 14'h0018;
      default: return 14'h0000;
    endcase
  endfunction

  function automatic refResult_t refPick(input intrPkg::intrVec_t flags,
                                         input intrPkg::intrVec_t mask,
                                         input seqRegPkg::icntl_t ctl);
    refResult_t        r;
    intrPkg::intrVec_t pend;
    logic              found;
    r     = '0;
    pend  = flags & mask;
    found = 1'b0;
    // first pending source from the top index wins
    for (int i = intrPkg::NUM_SRC - 1; i >= 0; i--) begin
      if (pend[i] && !found) begin
        found    = 1'b1;
        r.winner = 3'(i);
        r.vector = expVector(i);
        for (int j = i + 1; j < intrPkg::NUM_SRC; j++) begin
          r.newMask[j] = ctl.nest & mask[j];
        end
      end
    end
    r.hit = found & ctl.globalEn;
    return r;
  endfunction

  //////////////////////////////
  // bus and check tasks
  //////////////////////////////
  task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic writeReg(input seqRegPkg::regAddr_e addr, input logic [15:0] data);
    @(negedge DSPCLK);
    regWr.we   = 1'b1;
    regWr.addr = addr;
    regWr.data = data;
    @(negedge DSPCLK);
    regWr.we = 1'b0;
  endtask

  task automatic readReg(input seqRegPkg::regAddr_e addr, output logic [15:0] data);
    @(negedge DSPCLK);
    regRdAddr = addr;
    #1;
    data = regRdData;
  endtask

  task automatic checkReg(input seqRegPkg::regAddr_e addr, input logic [15:0] exp,
                          input string name);
    logic [15:0] d;
    readReg(addr, d);
    checkEq(name, d, exp);
  endtask

  task automatic setIcntl(input logic nest, input logic globalEn, input logic [2:0] edgeSel);
    seqRegPkg::icntl_t c;
    c.nest     = nest;
    c.globalEn = globalEn;
    c.irq2Edge = edgeSel[2];
    c.irq1Edge = edgeSel[1];
    c.irq0Edge = edgeSel[0];
    writeReg(seqRegPkg::REG_ICNTL, 16'(c));
    curIcntl = c;
    checkReg(seqRegPkg::REG_ICNTL, 16'(c), "ICNTL");
  endtask

  task automatic setMask(input intrPkg::intrVec_t m);
    writeReg(seqRegPkg::REG_IMASK, {10'h000, m});
    expMask = m;
  endtask

  // pinSel follows irqPins order with irq2n on top
  task automatic pulsePins(input logic [3:0] pinSel, input logic [1:0] reqSel);
    @(negedge DSPCLK);
    irqPins         = intrPkg::irqPins_t'(~pinSel);
    periphReq.timer = reqSel[0];
    periphReq.sport = reqSel[1];
    @(negedge DSPCLK);
    periphReq = '0;
    @(negedge DSPCLK);
    irqPins = '1;
  endtask

  task automatic waitTrap();
    int waited;
    waited = 0;
    @(negedge DSPCLK);
    #1;
    while (!trapReq && waited < TRAP_WAIT) begin
      @(negedge DSPCLK);
      #1;
      waited++;
    end
    if (!trapReq) begin
      $display("trapReq_o did not rise within %0d cycles", TRAP_WAIT);
      errCount++;
    end
  endtask

  task automatic checkTrapLow(input int cycles);
    repeat (cycles) begin
      @(negedge DSPCLK);
      #1;
      checkEq("trapReq_o", {15'h0000, trapReq}, 16'h0000);
    end
  endtask

  task automatic waitFlags(input intrPkg::intrVec_t exp);
    logic [15:0] d;
    int          waited;
    waited = 0;
    readReg(seqRegPkg::REG_IFLAG, d);
    while (d[5:0] !== exp && waited < FLAG_WAIT) begin
      readReg(seqRegPkg::REG_IFLAG, d);
      waited++;
    end
    checkEq("IFLAG", d, {10'h000, exp});
  endtask

  // model takes the flags read in the take cycle
  task automatic takeCheck(output logic [2:0] winner);
    refResult_t  r;
    logic [15:0] f;
    @(negedge DSPCLK);
    regRdAddr = seqRegPkg::REG_IFLAG;
    takeInt   = 1'b1;
    #1;
    f = regRdData;
    r = refPick(f[5:0], expMask, curIcntl);
    checkEq("trapReq_o", {15'h0000, trapReq}, {15'h0000, r.hit});
    @(negedge DSPCLK);
    takeInt = 1'b0;
    if (r.hit) begin
      checkEq("vector_o", {2'b00, vector}, {2'b00, r.vector});
      if (stackModel.size() < intrPkg::MASK_STACK_DEPTH) begin
        stackModel.push_back(expMask);
      end else begin
        expOvf = 1'b1;
      end
      expMask = r.newMask;
    end
    winner = r.winner;
    checkReg(seqRegPkg::REG_IMASK, {10'h000, expMask}, "IMASK");
  endtask

  task automatic rtiCheck();
    @(negedge DSPCLK);
    rti = 1'b1;
    @(negedge DSPCLK);
    rti = 1'b0;
    if (stackModel.size() > 0) begin
      expMask = stackModel.pop_back();
    end
    checkReg(seqRegPkg::REG_IMASK, {10'h000, expMask}, "IMASK");
  endtask

  task automatic checkSstat();
    checkReg(seqRegPkg::REG_SSTAT, {14'h0000, expOvf, stackModel.size() == 0}, "SSTAT");
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    logic [2:0]  win;
    logic [15:0] d;
    logic [31:0] rnd;
    logic [3:0]  pinSel;
    logic [1:0]  reqSel;
    void'($urandom(32'hc925));
    SRST      = 1'b1;
    irqPins   = '1;
    periphReq = '0;
    regWr     = '0;
    regRdAddr = seqRegPkg::REG_IMASK;
    takeInt   = 1'b0;
    rti       = 1'b0;
    expMask   = '0;
    expOvf    = 1'b0;
    curIcntl  = '0;
    repeat (3) @(posedge DSPCLK);
    @(negedge DSPCLK);
    SRST = 1'b0;

    // reset values
    #1;
    checkEq("trapReq_o", {15'h0000, trapReq}, 16'h0000);
    checkEq("vector_o", {2'b00, vector}, 16'h0000);
    checkReg(seqRegPkg::REG_IMASK, 16'h0000, "IMASK");
    checkReg(seqRegPkg::REG_IFLAG, 16'h0000, "IFLAG");
    checkSstat();

    // one source at a time in edge mode
    setIcntl(1'b0, 1'b1, 3'b111);
    setMask(6'h3f);
    for (int src = 0; src < intrPkg::NUM_SRC; src++) begin
      if (src < 2) begin
        pulsePins(4'h0, 2'(1 << src));
      end else begin
        pulsePins(4'(1 << (src - 2)), 2'b00);
      end
      waitTrap();
      takeCheck(win);
      checkEq("winner", {13'h0000, win}, 16'(src));
      checkEq("vector_o", {2'b00, vector}, {2'b00, expVector(src)});
      readReg(seqRegPkg::REG_IFLAG, d);
      checkEq("IFLAG bit", {15'h0000, d[src]}, 16'h0000);
      rtiCheck();
    end

    // random pending sets behind a random mask
    for (int it = 0; it < RAND_ITERS; it++) begin
      rnd    = $urandom;
      pinSel = rnd[3:0];
      reqSel = rnd[5:4];
      setMask(rnd[13:8]);
      pulsePins(pinSel, reqSel);
      waitFlags({pinSel, reqSel});
      if (({pinSel, reqSel} & expMask) == '0) begin
        checkTrapLow(3);
      end
      takeCheck(win);
      rtiCheck();
      writeReg(seqRegPkg::REG_IFC, 16'h003f);
    end

    ////////////////////////////// nesting and stack
    setIcntl(1'b1, 1'b1, 3'b111);
    setMask(6'h3f);
    writeReg(seqRegPkg::REG_IFC, {2'b00, 6'h01, 8'h00});
    takeCheck(win);
    checkSstat();
    rtiCheck();
    checkSstat();
    for (int k = 0; k < 5; k++) begin
      writeReg(seqRegPkg::REG_IFC, {2'b00, 6'(1 << k), 8'h00});
      takeCheck(win);
    end
    checkSstat();
    repeat (5) rtiCheck();
    checkSstat();

    // force and clear with global enable off
    setIcntl(1'b0, 1'b0, 3'b111);
    setMask(6'h3f);
    writeReg(seqRegPkg::REG_IFC, {2'b00, 6'h3f, 8'h00});
    checkReg(seqRegPkg::REG_IFLAG, 16'h003f, "IFLAG");
    checkReg(seqRegPkg::REG_IFC, 16'h0000, "IFC");
    checkTrapLow(4);
    writeReg(seqRegPkg::REG_IFC, 16'h0015);
    checkReg(seqRegPkg::REG_IFLAG, 16'h002a, "IFLAG");
    writeReg(seqRegPkg::REG_IFC, 16'h002a);
    checkReg(seqRegPkg::REG_IFLAG, 16'h0000, "IFLAG");

    // IRQ1 in level mode
    setIcntl(1'b0, 1'b1, 3'b101);
    @(negedge DSPCLK);
    irqPins.irq1n = 1'b0;
    waitTrap();
    takeCheck(win);
    checkEq("winner", {13'h0000, win}, 16'(intrPkg::IRQ1));
    readReg(seqRegPkg::REG_IFLAG, d);
    checkEq("IFLAG bit", {15'h0000, d[intrPkg::IRQ1]}, 16'h0001);
    rtiCheck();
    @(negedge DSPCLK);
    irqPins.irq1n = 1'b1;
    waitFlags('0);

    $display("checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
